//--- files.f
source/ddr5_pkg.sv
source/burst_pkg.sv
source/burst_ifs.sv
source/burst_handler.sv
source/timing_controller.sv
source/ddr5_cmd_encoder.sv
source/ddr5_data_path.sv
source/ddr5_burst_subsystem.sv
tests/ddr5_burst_assertions.sv
tests/tb_ddr5_burst.sv

//--- run_sim.sh
#!/bin/sh
# build and run the DDR5 burst regression with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_ddr5_burst -f files.f > build.log 2>&1 \
	&& ./obj_dir/Vtb_ddr5_burst > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
grep -q "Regression failed" sim.log && exit 1 || exit 0

//--- source/burst_handler.sv
`timescale 1ns/10ps
`default_nettype none

module burst_handler import burst_pkg::*; #(
	parameter int no_of_bursts = 4
) (
	input logic clk,
	input logic rst_n,
	input logic arbiter_valid,
	input req_address_u in_req_address,
	input logic [data_width-1:0] arbiter_data,
	input logic [read_entries_log-1:0] arbiter_index,
	input r_type arbiter_type,
	output logic start_new_burst,
	output logic returner_valid,
	output r_type returner_type,
	output logic [data_width-1:0] returner_data,
	output logic [read_entries_log-1:0] returner_index,
	burst_status_if.handler status,
	burst_cmd_if.handler cmd_bus
);

	localparam int idx_w = $clog2(no_of_bursts);

	burst_states_type [no_of_bursts-1:0] state;
	logic [no_of_bursts-1:0][burst_length-1:0] mask; // beats with a pending request
	logic [beat_width:0] done [no_of_bursts]; // beats gone by on the bus
	r_type slot_type [no_of_bursts];
	logic [key_width-1:0] slot_key [no_of_bursts];
	logic [data_width-1:0] slot_data [no_of_bursts][burst_length];
	logic [read_entries_log-1:0] slot_index [no_of_bursts][burst_length];

	logic [idx_w:0] empty_cnt;
	logic [idx_w:0] empty_next;
	logic armed; // low until the first edge out of reset
	logic [idx_w-1:0] open_slot;
	logic open_valid;
	logic append;
	logic open_new;
	logic have_empty;
	logic [idx_w-1:0] first_empty;
	logic [idx_w-1:0] in_slot;
	logic [burst_length-1:0] new_bit;
	logic [beat_width-1:0] low_beat [no_of_bursts];
	logic ret_any;
	logic [idx_w-1:0] ret_slot;
	logic free_any;
	logic [idx_w-1:0] free_slot;

	assign new_bit = {{(burst_length-1){1'b0}}, 1'b1} << in_req_address.split.beat;

	always_comb begin
		open_valid = (state[open_slot] == started_filling);
		append = arbiter_valid && open_valid
			&& slot_key[open_slot] == in_req_address.split.key
			&& slot_type[open_slot] == arbiter_type
			&& !(|(mask[open_slot] & new_bit)); // repeated beat opens a new burst
		have_empty = 1'b0;
		first_empty = '0;
		for (int i = no_of_bursts - 1; i >= 0; i--) begin
			if (state[i] == empty) begin
				have_empty = 1'b1;
				first_empty = idx_w'(i);
			end
		end
		open_new = arbiter_valid && !append && have_empty;
		in_slot = append ? open_slot : first_empty;
	end

	// lowest pending beat per slot, lowest slot wins
	always_comb begin
		ret_any = 1'b0;
		ret_slot = '0;
		free_any = 1'b0;
		free_slot = '0;
		for (int i = no_of_bursts - 1; i >= 0; i--) begin
			low_beat[i] = '0;
			for (int b = burst_length - 1; b >= 0; b--) begin
				if (mask[i][b])
					low_beat[i] = beat_width'(b);
			end
			if (state[i] == returning_data && |mask[i] && done[i] > {1'b0, low_beat[i]}) begin
				ret_any = 1'b1;
				ret_slot = idx_w'(i);
			end
			if (state[i] == returning_data && mask[i] == '0
				&& done[i] == (beat_width+1)'(burst_length)) begin
				free_any = 1'b1;
				free_slot = idx_w'(i);
			end
		end
	end

	assign empty_next = empty_cnt - (idx_w+1)'(open_new) + (idx_w+1)'(free_any);
	assign start_new_burst = armed && (empty_cnt >= 2 || (empty_cnt == 1 && !arbiter_valid));

	always_comb begin
		for (int i = 0; i < no_of_bursts; i++) begin
			status.state[i] = state[i];
			status.the_type[i] = slot_type[i];
			status.address[i].split.key = slot_key[i];
			status.address[i].split.beat = '0; // bursts start at beat 0
		end
	end

	assign cmd_bus.wr_data = slot_data[cmd_bus.cmd_index][cmd_bus.beat_count];
	assign cmd_bus.wr_mask = mask[cmd_bus.cmd_index][cmd_bus.beat_count];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < no_of_bursts; i++) begin
				state[i] <= empty;
				mask[i] <= '0;
				done[i] <= '0;
			end
			empty_cnt <= (idx_w+1)'(no_of_bursts);
			armed <= 1'b0;
			open_slot <= '0;
			returner_valid <= 1'b0;
		end else begin
			armed <= 1'b1;
			empty_cnt <= empty_next;
			returner_valid <= ret_any;
			if (open_new)
				open_slot <= first_empty;
			for (int i = 0; i < no_of_bursts; i++) begin
				if (open_valid && open_slot == idx_w'(i) && !append)
					state[i] <= full; // gap, new key or new type
				if (append && open_slot == idx_w'(i)) begin
					mask[i] <= mask[i] | new_bit;
					if (&(mask[i] | new_bit))
						state[i] <= full; // all beats taken
				end
				if (open_new && first_empty == idx_w'(i)) begin
					state[i] <= started_filling;
					mask[i] <= new_bit;
					done[i] <= '0;
				end
				if (status.slot_release && status.release_index == idx_w'(i))
					state[i] <= issued;
				if (cmd_bus.beat_valid && cmd_bus.cmd_index == idx_w'(i)
					&& (state[i] == issued || state[i] == returning_data)) begin
					state[i] <= returning_data;
					done[i] <= (beat_width+1)'(cmd_bus.beat_num) + 1'b1;
				end
				if (ret_any && ret_slot == idx_w'(i))
					mask[i][low_beat[i]] <= 1'b0;
				if (free_any && free_slot == idx_w'(i))
					state[i] <= empty;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (open_new) begin
			slot_key[first_empty] <= in_req_address.split.key;
			slot_type[first_empty] <= arbiter_type;
		end
		if (append || open_new) begin
			slot_index[in_slot][in_req_address.split.beat] <= arbiter_index;
			if (arbiter_type == write)
				slot_data[in_slot][in_req_address.split.beat] <= arbiter_data;
		end
		if (cmd_bus.beat_valid && slot_type[cmd_bus.cmd_index] == read
			&& (state[cmd_bus.cmd_index] == issued || state[cmd_bus.cmd_index] == returning_data))
			slot_data[cmd_bus.cmd_index][cmd_bus.beat_num] <= cmd_bus.beat_data; // read beat
		if (ret_any) begin
			returner_type <= slot_type[ret_slot];
			returner_index <= slot_index[ret_slot][low_beat[ret_slot]];
			returner_data <= slot_data[ret_slot][low_beat[ret_slot]];
		end
	end

endmodule

`default_nettype wire

//--- source/burst_ifs.sv
`timescale 1ns/10ps
`default_nettype none

interface burst_status_if import burst_pkg::*; #(parameter int no_of_bursts = 4);

	localparam int idx_w = $clog2(no_of_bursts);

	burst_states_type [no_of_bursts-1:0] state;
	r_type [no_of_bursts-1:0] the_type;
	req_address_u [no_of_bursts-1:0] address; // burst start address per slot
	logic slot_release; // slot taken by the controller
	logic [idx_w-1:0] release_index;

	modport handler (output state, the_type, address, input slot_release, release_index);
	modport controller (input state, the_type, address, output slot_release, release_index);

endinterface

interface burst_cmd_if import ddr5_pkg::*, burst_pkg::*; #(parameter int no_of_bursts = 4);

	localparam int idx_w = $clog2(no_of_bursts);

	command cmd; // one-cycle pulse per command
	logic [idx_w-1:0] cmd_index;
	req_address_u cmd_address;
	logic [beat_width-1:0] beat_count; // beat on the pins now
	logic beat_valid; // one cycle after each beat
	logic [beat_width-1:0] beat_num;
	logic [data_width-1:0] beat_data; // captured read word
	logic data_done;
	logic [data_width-1:0] wr_data;
	logic wr_mask;

	modport controller (output cmd, cmd_index, cmd_address, input data_done);
	modport encoder (input cmd, cmd_address);
	modport data (input cmd, wr_data, wr_mask,
		output beat_count, beat_valid, beat_num, beat_data, data_done);
	modport handler (input cmd_index, beat_count, beat_valid, beat_num, beat_data,
		output wr_data, wr_mask);

endinterface

`default_nettype wire

//--- source/burst_pkg.sv
`default_nettype none

package burst_pkg;

	localparam int data_width = 16;
	localparam int read_entries_log = 4;
	localparam int burst_length = 16;
	localparam int beat_width = $clog2(burst_length);
	localparam int key_width = 20; // bank group, bank and row

	typedef enum logic {
		read,
		write
	} r_type;

	typedef enum logic [2:0] {
		empty,
		started_filling,
		full,
		issued,
		returning_data
	} burst_states_type;

	// one request address, seen as DDR5 fields or as burst key plus beat
	typedef union packed {
		struct packed {
			logic [1:0] bank_group;
			logic [1:0] bank;
			logic [15:0] row;
			logic [3:0] column;
		} fields;
		struct packed {
			logic [key_width-1:0] key;
			logic [beat_width-1:0] beat;
		} split;
	} req_address_u;

endpackage

`default_nettype wire

//--- source/ddr5_burst_subsystem.sv
`timescale 1ns/10ps
`default_nettype none

module ddr5_burst_subsystem import ddr5_pkg::*, burst_pkg::*; #(
	parameter int no_of_bursts = 4,
	parameter int refresh_interval = 200
) (
	input logic clk,
	input logic rst_n,
	input logic arbiter_valid,
	input req_address_u in_req_address,
	input logic [data_width-1:0] arbiter_data,
	input logic [read_entries_log-1:0] arbiter_index,
	input r_type arbiter_type,
	output logic start_new_burst,
	output logic cs_n,
	output logic [ca_width-1:0] ca,
	output logic [data_width-1:0] dq_out,
	output logic dq_oe,
	input logic [data_width-1:0] dq_in,
	output logic returner_valid,
	output r_type returner_type,
	output logic [data_width-1:0] returner_data,
	output logic [read_entries_log-1:0] returner_index
);

	burst_status_if #(.no_of_bursts(no_of_bursts)) status_bus ();
	burst_cmd_if #(.no_of_bursts(no_of_bursts)) cmd_bus ();

	burst_handler #(.no_of_bursts(no_of_bursts)) i_handler (
		.clk(clk),
		.rst_n(rst_n),
		.arbiter_valid(arbiter_valid),
		.in_req_address(in_req_address),
		.arbiter_data(arbiter_data),
		.arbiter_index(arbiter_index),
		.arbiter_type(arbiter_type),
		.start_new_burst(start_new_burst),
		.returner_valid(returner_valid),
		.returner_type(returner_type),
		.returner_data(returner_data),
		.returner_index(returner_index),
		.status(status_bus.handler),
		.cmd_bus(cmd_bus.handler)
	);

	timing_controller #(
		.no_of_bursts(no_of_bursts),
		.refresh_interval(refresh_interval)
	) i_controller (
		.clk(clk),
		.rst_n(rst_n),
		.status(status_bus.controller),
		.cmd_bus(cmd_bus.controller)
	);

	ddr5_cmd_encoder i_encoder (
		.clk(clk),
		.rst_n(rst_n),
		.cmd_bus(cmd_bus.encoder),
		.cs_n(cs_n),
		.ca(ca)
	);

	ddr5_data_path i_data_path (
		.clk(clk),
		.rst_n(rst_n),
		.cmd_bus(cmd_bus.data),
		.dq_out(dq_out),
		.dq_oe(dq_oe),
		.dq_in(dq_in)
	);

endmodule

`default_nettype wire

//--- source/ddr5_cmd_encoder.sv
`timescale 1ns/10ps
`default_nettype none

module ddr5_cmd_encoder import ddr5_pkg::*, burst_pkg::*; (
	input logic clk,
	input logic rst_n,
	burst_cmd_if.encoder cmd_bus,
	output logic cs_n,
	output logic [ca_width-1:0] ca
);

	command pend; // command waiting for its phase two
	req_address_u addr_q;
	req_address_u a;

	assign a = cmd_bus.cmd_address;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cs_n <= 1'b1;
			ca <= '0;
			pend <= none;
		end else begin
			cs_n <= 1'b1;
			ca <= '0;
			pend <= cmd_bus.cmd;
			case (cmd_bus.cmd)
				activate: ca <= {4'b0, a.fields.bank_group, a.fields.bank, a.fields.row[3:0],
					op_activate};
				read_cmd: ca <= {4'b0, a.fields.bank_group, a.fields.bank, bl_n, op_read};
				write_cmd: ca <= {4'b0, a.fields.bank_group, a.fields.bank, bl_n, op_write};
				precharge: ca <= {4'b0, a.fields.bank_group, a.fields.bank, op_precharge};
				refresh_all: ca <= op_refresh_all; // no phase two
				default: begin
					case (pend)
						activate: ca <= {2'b0, addr_q.fields.row[15:4]};
						read_cmd: ca <= {6'b0, ap_n, 1'b0, addr_q.fields.column, 2'b01};
						write_cmd: ca <= {6'b0, ap_n, 1'b0, addr_q.fields.column, 2'b00};
						default: ca <= '0;
					endcase
				end
			endcase
			if (cmd_bus.cmd != none)
				cs_n <= 1'b0; // phase one
		end
	end

	always_ff @(posedge clk) begin
		if (cmd_bus.cmd != none)
			addr_q <= cmd_bus.cmd_address;
	end

endmodule

`default_nettype wire

//--- source/ddr5_data_path.sv
`timescale 1ns/10ps
`default_nettype none

module ddr5_data_path import ddr5_pkg::*, burst_pkg::*; (
	input logic clk,
	input logic rst_n,
	burst_cmd_if.data cmd_bus,
	output logic [data_width-1:0] dq_out,
	output logic dq_oe,
	input logic [data_width-1:0] dq_in
);

	localparam int cnt_w = $clog2(rd_to_data + burst_length + 1);

	logic busy;
	logic is_read;
	logic [cnt_w-1:0] cnt; // 1 in the phase one cycle
	logic [cnt_w-1:0] lat;
	logic in_window;

	assign lat = is_read ? cnt_w'(rd_to_data) : cnt_w'(wr_to_data);
	assign in_window = busy && cnt > lat;
	assign cmd_bus.beat_count = beat_width'(cnt - lat - 1'b1);

	assign dq_out = cmd_bus.wr_data;
	assign dq_oe = in_window && !is_read && cmd_bus.wr_mask; // masked write beats only

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			is_read <= 1'b0;
			cnt <= '0;
			cmd_bus.beat_valid <= 1'b0;
			cmd_bus.data_done <= 1'b0;
		end else begin
			cmd_bus.beat_valid <= in_window;
			cmd_bus.data_done <= in_window
				&& cmd_bus.beat_count == beat_width'(burst_length - 1);
			if (cmd_bus.cmd == read_cmd || cmd_bus.cmd == write_cmd) begin
				busy <= 1'b1;
				is_read <= (cmd_bus.cmd == read_cmd);
				cnt <= cnt_w'(1);
			end else if (busy) begin
				cnt <= cnt + 1'b1;
				if (cnt == lat + cnt_w'(burst_length))
					busy <= 1'b0; // last beat
			end
		end
	end

	always_ff @(posedge clk) begin
		if (in_window) begin
			cmd_bus.beat_data <= dq_in;
			cmd_bus.beat_num <= cmd_bus.beat_count;
		end
	end

endmodule

`default_nettype wire

//--- source/ddr5_pkg.sv
`default_nettype none

package ddr5_pkg;

	typedef enum logic [2:0] {
		none,
		activate,
		read_cmd,
		write_cmd,
		precharge,
		refresh_all
	} command;

	localparam int ca_width = 14;

	// cycles from command phase one to the first data beat
	localparam int rd_to_data = 11;
	localparam int wr_to_data = 8;

	// waits after activate, precharge and refresh
	localparam int t_rcd = 4;
	localparam int t_rp = 4;
	localparam int t_rfc = 10;

	// phase one opcodes, placed in the low ca bits
	localparam logic [1:0] op_activate = 2'b00;
	localparam logic [4:0] op_read = 5'b11101;
	localparam logic [4:0] op_write = 5'b01101;
	localparam logic [5:0] op_precharge = 6'b011011;
	localparam logic [13:0] op_refresh_all = 14'b00000000010011;

	localparam logic bl_n = 1'b1; // burst length 16
	localparam logic ap_n = 1'b1; // no auto precharge

endpackage

`default_nettype wire

//--- source/timing_controller.sv
`timescale 1ns/10ps
`default_nettype none

module timing_controller import ddr5_pkg::*, burst_pkg::*; #(
	parameter int no_of_bursts = 4,
	parameter int refresh_interval = 200
) (
	input logic clk,
	input logic rst_n,
	burst_status_if.controller status,
	burst_cmd_if.controller cmd_bus
);

	localparam int idx_w = $clog2(no_of_bursts);
	localparam int ref_w = $clog2(refresh_interval);
	localparam int wait_w = $clog2(t_rfc + 1);

	localparam logic [2:0] st_idle = 3'd0;
	localparam logic [2:0] st_act = 3'd1; // after activate
	localparam logic [2:0] st_data = 3'd2; // burst on the bus
	localparam logic [2:0] st_pre = 3'd3;
	localparam logic [2:0] st_ref = 3'd4;

	logic [2:0] fsm;
	logic [wait_w-1:0] wait_cnt;
	logic [ref_w-1:0] ref_cnt;
	logic ref_pending;
	logic found;
	logic [idx_w-1:0] pick;

	always_comb begin
		found = 1'b0;
		pick = '0;
		for (int i = no_of_bursts - 1; i >= 0; i--) begin
			if (status.state[i] == full) begin
				found = 1'b1;
				pick = idx_w'(i);
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ref_cnt <= '0;
			ref_pending <= 1'b0;
		end else begin
			if (fsm == st_idle && ref_pending)
				ref_pending <= 1'b0; // refresh going out now
			if (ref_cnt == ref_w'(refresh_interval - 1)) begin
				ref_cnt <= '0;
				ref_pending <= 1'b1;
			end else
				ref_cnt <= ref_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fsm <= st_idle;
			wait_cnt <= '0;
			cmd_bus.cmd <= none;
			cmd_bus.cmd_index <= '0;
			cmd_bus.cmd_address <= '0;
			status.slot_release <= 1'b0;
			status.release_index <= '0;
		end else begin
			cmd_bus.cmd <= none;
			status.slot_release <= 1'b0;
			if (wait_cnt != 0)
				wait_cnt <= wait_cnt - 1'b1;
			case (fsm)
				st_idle: begin
					if (ref_pending) begin
						cmd_bus.cmd <= refresh_all;
						wait_cnt <= wait_w'(t_rfc - 1);
						fsm <= st_ref;
					end else if (found) begin
						cmd_bus.cmd <= activate;
						cmd_bus.cmd_index <= pick;
						cmd_bus.cmd_address <= status.address[pick];
						status.slot_release <= 1'b1;
						status.release_index <= pick;
						wait_cnt <= wait_w'(t_rcd - 1);
						fsm <= st_act;
					end
				end
				st_act: begin
					if (wait_cnt == 0) begin
						cmd_bus.cmd <= (status.the_type[cmd_bus.cmd_index] == write) ?
							write_cmd : read_cmd;
						fsm <= st_data;
					end
				end
				st_data: begin
					if (cmd_bus.data_done) begin
						cmd_bus.cmd <= precharge; // close the row again
						wait_cnt <= wait_w'(t_rp - 1);
						fsm <= st_pre;
					end
				end
				st_pre, st_ref: begin
					if (wait_cnt == 0)
						fsm <= st_idle;
				end
				default: fsm <= st_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- tests/ddr5_burst_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module ddr5_burst_assertions import ddr5_pkg::*, burst_pkg::*; #(
	parameter int no_of_bursts = 4
) (
	input logic clk,
	input logic rst_n,
	input logic start_new_burst,
	input logic cs_n,
	input logic [ca_width-1:0] ca,
	input logic dq_oe,
	input logic returner_valid,
	input logic [read_entries_log-1:0] returner_index,
	input burst_states_type [no_of_bursts-1:0] slot_state
);

	logic any_empty; // some slot really is empty

	always_comb begin
		any_empty = 1'b0;
		for (int i = 0; i < no_of_bursts; i++) begin
			if (slot_state[i] == empty)
				any_empty = 1'b1;
		end
	end

	// idle pins while reset is held
	a_reset_idle: assert property (@(posedge clk)
		!rst_n |-> cs_n && !dq_oe && !returner_valid && !start_new_burst)
		else $error("pins not idle during reset");

	// the arbiter is only invited when a slot is free
	a_new_burst_has_slot: assert property (@(posedge clk) disable iff (!rst_n)
		start_new_burst |-> any_empty)
		else $error("start_new_burst high with no empty slot");

	// phase two always has chip select high
	a_two_phase: assert property (@(posedge clk) disable iff (!rst_n)
		!cs_n |=> cs_n)
		else $error("chip select low on two cycles in a row");

	// nothing may follow a refresh until t_rfc has gone by
	a_refresh_gap: assert property (@(posedge clk) disable iff (!rst_n)
		(!cs_n && ca == op_refresh_all) |=> cs_n [*t_rfc])
		else $error("command issued within t_rfc of a refresh");

	a_return_known: assert property (@(posedge clk) disable iff (!rst_n)
		returner_valid |-> !$isunknown(returner_index))
		else $error("unknown returner_index on a return");

endmodule

`default_nettype wire

//--- tests/tb_ddr5_burst.sv
`timescale 1ns/10ps
`default_nettype none

module tb_ddr5_burst import ddr5_pkg::*, burst_pkg::*; ();

	localparam int max_cycles = 4000; // five short tests plus two refresh intervals

	logic clk;
	logic rst_n;
	logic arbiter_valid;
	logic [23:0] in_req_address;
	logic [data_width-1:0] arbiter_data;
	logic [read_entries_log-1:0] arbiter_index;
	r_type arbiter_type;
	logic start_new_burst;
	logic cs_n;
	logic [ca_width-1:0] ca;
	logic [data_width-1:0] dq_out;
	logic dq_oe;
	logic [data_width-1:0] dq_in;
	logic returner_valid;
	r_type returner_type;
	logic [data_width-1:0] returner_data;
	logic [read_entries_log-1:0] returner_index;

	int cyc;
	int errors;
	int test_start_errors;
	int tests_run;
	int outstanding;
	int refresh_count;
	int seen;
	logic [15:0] lfsr_state;
	bit exp_pending [16];
	r_type exp_type [16];
	logic [15:0] exp_data [16];
	int exp_order [$];
	bit order_on;
	logic [15:0] tb_mem [logic [23:0]]; // expected memory contents
	bit issued_keys [logic [19:0]];
	logic [15:0] mem [logic [23:0]]; // memory model storage
	logic [15:0] rd_sched [int]; // dq_in word per cycle
	bit act_p2;
	bit rw_p2;
	bit is_rd;
	bit row_open;
	logic [1:0] bg;
	logic [1:0] bk;
	logic [3:0] row_lo;
	logic [15:0] act_row;
	logic [23:0] base_addr;
	logic [23:0] wr_addr;
	int base_cyc;
	int wr_base;

	ddr5_burst_subsystem #(.no_of_bursts(4), .refresh_interval(200)) i_dut (
		.clk(clk),
		.rst_n(rst_n),
		.arbiter_valid(arbiter_valid),
		.in_req_address(in_req_address),
		.arbiter_data(arbiter_data),
		.arbiter_index(arbiter_index),
		.arbiter_type(arbiter_type),
		.start_new_burst(start_new_burst),
		.cs_n(cs_n),
		.ca(ca),
		.dq_out(dq_out),
		.dq_oe(dq_oe),
		.dq_in(dq_in),
		.returner_valid(returner_valid),
		.returner_type(returner_type),
		.returner_data(returner_data),
		.returner_index(returner_index)
	);

	bind ddr5_burst_subsystem ddr5_burst_assertions #(.no_of_bursts(no_of_bursts)) i_assertions (
		.clk(clk),
		.rst_n(rst_n),
		.start_new_burst(start_new_burst),
		.cs_n(cs_n),
		.ca(ca),
		.dq_oe(dq_oe),
		.returner_valid(returner_valid),
		.returner_index(returner_index),
		.slot_state(i_handler.state)
	);

	function automatic logic rand_bit();
		logic lsb;
		lsb = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (lsb)
			lfsr_state = lfsr_state ^ 16'hB400; // galois taps 16,14,13,11
		return lsb;
	endfunction

	function automatic logic [19:0] rand_bits(int n);
		logic [19:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
			r = {r[18:0], rand_bit()};
		return r;
	endfunction

	// unwritten words read back as row xor column
	function automatic logic [15:0] pattern(logic [23:0] addr);
		return addr[19:4] ^ {12'h0, addr[3:0]};
	endfunction

	task automatic value_error(string name, logic [31:0] got, logic [31:0] exp);
		$display("ERROR %s: got %h expected %h at cycle %0d", name, got, exp, cyc);
		errors++;
	endtask

	task automatic plain_error(string msg);
		$display("%s at cycle %0d", msg, cyc);
		errors++;
	endtask

	task automatic send_req(logic [23:0] addr, r_type t, logic [15:0] d, logic [3:0] idx);
		@(negedge clk);
		while (!start_new_burst) begin
			@(posedge clk);
			#1;
			arbiter_valid = 1'b0; // no request without an invitation
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		arbiter_valid = 1'b1;
		in_req_address = addr;
		arbiter_type = t;
		arbiter_data = d;
		arbiter_index = idx;
		exp_pending[idx] = 1'b1;
		exp_type[idx] = t;
		issued_keys[addr[23:4]] = 1'b1;
		outstanding++;
		if (t == write)
			tb_mem[addr] = d;
		else
			exp_data[idx] = tb_mem.exists(addr) ? tb_mem[addr] : pattern(addr);
	endtask

	task automatic idle_cycles(int n);
		repeat (n) begin
			@(posedge clk);
			#1;
			arbiter_valid = 1'b0;
		end
	endtask

	task automatic wait_returns();
		while (outstanding > 0)
			@(negedge clk);
	endtask

	task automatic finish_test(string name);
		tests_run++;
		$display("test %s finished with %0d errors", name, errors - test_start_errors);
		test_start_errors = errors;
	endtask

	task automatic column_burst(logic [19:0] key, logic [15:0] cols, r_type t);
		for (int c = 15; c >= 0; c--) begin
			if (cols[c])
				send_req({key, 4'(c)}, t, 16'(rand_bits(16)), 4'(c)); // descending on purpose
		end
		for (int c = 0; c < 16; c++) begin
			if (cols[c])
				exp_order.push_back(c);
		end
		idle_cycles(1);
		wait_returns();
	endtask

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		#1;
		cyc++;
		if (rd_sched.exists(cyc))
			dq_in = rd_sched[cyc];
		if (cyc >= max_cycles) begin
			$display("timeout after %0d cycles, %0d requests never returned", cyc, outstanding);
			$display("Regression failed");
			$finish;
		end
	end

	// reset and idle checks
	always @(negedge clk) begin
		if (!rst_n || cyc < 12) begin
			assert (cs_n && !dq_oe && !returner_valid)
				else plain_error("pins not idle around reset");
		end
	end

	// memory model decoding both command phases
	always @(negedge clk) begin
		if (rst_n) begin
			if (!cs_n) begin
				if (ca == op_refresh_all) begin
					assert (!row_open) else plain_error("refresh issued while a row is open");
					refresh_count++;
				end else if (ca[5:0] == op_precharge) begin
					row_open = 1'b0;
				end else if (ca[1:0] == op_activate) begin
					act_p2 = 1'b1;
					bg = ca[9:8];
					bk = ca[7:6];
					row_lo = ca[5:2];
					row_open = 1'b1;
				end else begin
					rw_p2 = 1'b1;
					is_rd = (ca[4:0] == op_read);
					bg = ca[9:8];
					bk = ca[7:6];
					base_cyc = cyc;
				end
			end else if (act_p2) begin
				act_p2 = 1'b0;
				act_row = {ca[11:0], row_lo};
				assert (issued_keys.exists({bg, bk, act_row}))
					else plain_error($sformatf("activate of key %h that no request named",
						{bg, bk, act_row}));
			end else if (rw_p2) begin
				rw_p2 = 1'b0;
				base_addr = {bg, bk, act_row, ca[5:2]};
				if (is_rd) begin
					for (int k = 0; k < burst_length; k++) begin
						wr_addr = {base_addr[23:4], 4'(k)};
						rd_sched[base_cyc + rd_to_data + k] = mem.exists(wr_addr) ?
							mem[wr_addr] : pattern(wr_addr);
					end
				end else
					wr_base = base_cyc + wr_to_data;
			end
			if (dq_oe) begin
				wr_addr = {base_addr[23:4], 4'(cyc - wr_base)};
				mem[wr_addr] = dq_out;
				assert (tb_mem.exists(wr_addr) && dq_out == tb_mem[wr_addr])
					else value_error("dq_out", 32'(dq_out),
						tb_mem.exists(wr_addr) ? 32'(tb_mem[wr_addr]) : 32'(0));
			end
		end
	end

	// returner checks
	always @(negedge clk) begin
		if (rst_n && returner_valid) begin
			assert (exp_pending[returner_index])
				else plain_error("return for an index that has no pending request");
			assert (returner_type == exp_type[returner_index])
				else value_error("returner_type", 32'(returner_type),
					32'(exp_type[returner_index]));
			if (returner_type == read) begin
				assert (returner_data == exp_data[returner_index])
					else value_error("returner_data", 32'(returner_data),
						32'(exp_data[returner_index]));
			end
			if (order_on && exp_order.size() > 0) begin
				assert (32'(returner_index) == exp_order[0])
					else value_error("returner_index", 32'(returner_index), exp_order[0]);
				void'(exp_order.pop_front());
			end
			exp_pending[returner_index] = 1'b0;
			outstanding--;
		end
	end

	initial begin
		logic [19:0] key;
		logic [15:0] cols;
		rst_n = 1'b1;
		arbiter_valid = 1'b0;
		in_req_address = '0;
		arbiter_data = '0;
		arbiter_index = '0;
		arbiter_type = read;
		dq_in = '0;
		lfsr_state = 16'd98;
		#1;
		rst_n = 1'b0;
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;
		idle_cycles(3);
		assert (start_new_burst) else plain_error("start_new_burst low after reset");
		finish_test("reset");

		order_on = 1'b1;
		key = rand_bits(20);
		cols = 16'(rand_bits(16)) | 16'h0101;
		column_burst(key, cols, read);
		finish_test("gathered_reads");

		key = rand_bits(20);
		cols = 16'(rand_bits(16)) | 16'h0011;
		column_burst(key, cols, write);
		column_burst(key, cols, read); // reads back the written words
		finish_test("write_then_read");

		order_on = 1'b0;
		key = rand_bits(20);
		send_req({key, 4'd1}, read, '0, 4'd0);
		send_req({key, 4'd2}, read, '0, 4'd1);
		key = rand_bits(20);
		send_req({key, 4'd3}, read, '0, 4'd2); // new key
		send_req({key, 4'd4}, write, 16'(rand_bits(16)), 4'd3); // new type
		idle_cycles(2);
		send_req({key, 4'd5}, read, '0, 4'd4); // after a gap
		send_req({rand_bits(20), 4'd0}, read, '0, 4'd5);
		send_req({rand_bits(20), 4'd7}, write, 16'(rand_bits(16)), 4'd6);
		send_req({rand_bits(20), 4'd9}, read, '0, 4'd7);
		idle_cycles(1);
		wait_returns();
		finish_test("burst_splitting");

		seen = refresh_count;
		while (refresh_count <= seen)
			@(negedge clk);
		finish_test("refresh");

		$display("%0d tests run, %0d errors", tests_run, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire
